/* filelist.f */
+incdir+include
hw/ebi_pkg.sv
hw/sync_fifo.sv
hw/ebi_bridge.sv
hw/acq_sequencer.sv
hw/ebi_top.sv
test/tb_ebi_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_ebi_top \
  -Mdir obj_dir

sim_status=0
sim_output=$(./obj_dir/Vtb_ebi_top 2>&1) || sim_status=$?
printf '%s\n' "$sim_output"

if grep -qF '*** PASSED ***' <<< "$sim_output"; then
  echo "Simulation result: pass"
  exit 0
fi

echo "Simulation result: fail (exit status ${sim_status})"
exit 1

/* test/tb_ebi_top.sv */
`include "ebi_defs.svh"

module tb_ebi_top;

  localparam int NUM_ENTRIES = 11;
  // Entries below this index run one at a time, the rest back to back
  localparam int NUM_SINGLE  = 6;
  localparam int POLL_LIMIT  = 20;
  localparam int IRQ_LIMIT   = 100;

  logic           clk;
  logic           rst;
  logic           cs;
  logic           rd;
  logic           wr;
  ebi_pkg::addr_t addr;
  ebi_pkg::data_t data_in;
  ebi_pkg::data_t data_out;
  logic           irq;

  ebi_pkg::cmd_t    table_cmd [NUM_ENTRIES];
  ebi_pkg::data_t   expected_q [$];
  ebi_pkg::status_t idle_status;
  integer           seed;
  int               total_samples;
  int               sample_idx;
  logic             table_ready;

  ebi_top UUT (
    .clk      (clk),
    .rst      (rst),
    .cs       (cs),
    .rd       (rd),
    .wr       (wr),
    .addr     (addr),
    .data_in  (data_in),
    .data_out (data_out),
    .irq      (irq)
  );

  always #50 clk = ~clk;

  // --------------------
  // Reporting
  // --------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("Error %s: got %h expected %h", name, got, expected));
    end
  endtask

  // --------------------
  // Host bus
  // --------------------
  task automatic host_write(input ebi_pkg::addr_t a, input ebi_pkg::data_t d);
    @(posedge clk);
    #5;
    cs      = 1'b1;
    wr      = 1'b1;
    addr    = a;
    data_in = d;
    repeat (3) @(posedge clk);
    #5;
    cs = 1'b0;
    wr = 1'b0;
    @(posedge clk);
  endtask

  task automatic host_read(input ebi_pkg::addr_t a, output ebi_pkg::data_t d);
    @(posedge clk);
    #5;
    cs   = 1'b1;
    rd   = 1'b1;
    addr = a;
    repeat (3) @(posedge clk);
    #5;
    // data_out was loaded on the strobe edges
    d  = data_out;
    cs = 1'b0;
    rd = 1'b0;
    @(posedge clk);
  endtask

  task automatic send_command(input ebi_pkg::cmd_t c);
    host_write(`EBI_ADDR_CMD_W1, c.opcode);
    host_write(`EBI_ADDR_CMD_W2, c.count);
    host_write(`EBI_ADDR_CMD_W3, c.start);
    host_write(`EBI_ADDR_CMD_W4, c.step);
    host_write(`EBI_ADDR_CMD_W5, c.mask);
  endtask

  // Poll status until the holding register is full, then fetch it
  task automatic read_next_sample(output ebi_pkg::data_t value);
    ebi_pkg::data_t   word;
    ebi_pkg::status_t st;
    int               polls;
    polls = 0;
    st    = '0;
    while (!st.sample_valid) begin
      if (polls == POLL_LIMIT) begin
        abort_run("No sample became valid while polling the status register");
      end
      host_read(`EBI_ADDR_STATUS, word);
      st = word;
      polls++;
    end
    host_read(`EBI_ADDR_SAMPLE, value);
  endtask

  task automatic wait_for_irq();
    int n;
    n = 0;
    while (irq !== 1'b1) begin
      if (n == IRQ_LIMIT) begin
        abort_run("irq did not rise after the status changed");
      end
      @(posedge clk);
      #5;
      n++;
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  function automatic int count_samples(input ebi_pkg::cmd_t c);
    if (c.opcode == `EBI_OP_RAMP || c.opcode == `EBI_OP_CONST) begin
      return int'(c.count);
    end
    return 0;
  endfunction

  task automatic add_expected(input ebi_pkg::cmd_t c);
    ebi_pkg::data_t value;
    int             n;
    n = count_samples(c);
    for (int k = 0; k < n; k++) begin
      if (c.opcode == `EBI_OP_RAMP) begin
        value = c.start + 16'(k) * c.step;
      end else begin
        value = c.start;
      end
      expected_q.push_back(value ^ c.mask);
    end
  endtask

  task automatic drain_expected();
    ebi_pkg::data_t got;
    ebi_pkg::data_t exp;
    while (expected_q.size() > 0) begin
      read_next_sample(got);
      exp = expected_q.pop_front();
      check_value($sformatf("data_out (sample %0d)", sample_idx), got, exp);
      sample_idx++;
    end
  endtask

  function automatic ebi_pkg::data_t next_random();
    return 16'($random(seed));
  endfunction

  function automatic ebi_pkg::cmd_t make_cmd(input ebi_pkg::data_t opcode,
                                             input ebi_pkg::data_t count,
                                             input ebi_pkg::data_t start,
                                             input ebi_pkg::data_t step,
                                             input ebi_pkg::data_t mask);
    ebi_pkg::cmd_t c;
    c.opcode = opcode;
    c.count  = count;
    c.start  = start;
    c.step   = step;
    c.mask   = mask;
    return c;
  endfunction

  task automatic build_table();
    ebi_pkg::data_t r_start;
    ebi_pkg::data_t r_step;
    table_cmd[0] = make_cmd(`EBI_OP_RAMP, 16'd8, 16'h0010, 16'h0003, 16'h0000);
    // Wraps past 16'hFFFF
    table_cmd[1] = make_cmd(`EBI_OP_RAMP, 16'd6, 16'hFFF0, 16'h0007, 16'h00FF);
    table_cmd[2] = make_cmd(`EBI_OP_CONST, 16'd5, 16'h1234, 16'h0000, 16'h0F0F);
    table_cmd[3] = make_cmd(16'h0007, 16'd9, 16'h5555, 16'h0001, 16'h0000);
    table_cmd[4] = make_cmd(`EBI_OP_RAMP, 16'd0, 16'h0100, 16'h0001, 16'h0000);
    r_start = next_random();
    r_step  = next_random();
    // Longer than the sample FIFO
    table_cmd[5] = make_cmd(`EBI_OP_RAMP, 16'd40, r_start, r_step, 16'hA5A5);
    r_start = next_random();
    r_step  = next_random();
    table_cmd[6] = make_cmd(`EBI_OP_RAMP, 16'd20, r_start, r_step, 16'h0000);
    r_start = next_random();
    table_cmd[7] = make_cmd(`EBI_OP_CONST, 16'd3, r_start, 16'h0000, 16'h00FF);
    table_cmd[8] = make_cmd(16'h0000, 16'd4, 16'h0F00, 16'h0010, 16'h0000);
    table_cmd[9] = make_cmd(`EBI_OP_RAMP, 16'd7, 16'hFFFE, 16'h8001, 16'h0000);
    table_cmd[10] = make_cmd(`EBI_OP_RAMP, 16'd0, 16'h2222, 16'h0002, 16'h0000);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    ebi_pkg::data_t word;
    clk         = 1'b0;
    rst         = 1'b1;
    cs          = 1'b0;
    rd          = 1'b0;
    wr          = 1'b0;
    addr        = '0;
    data_in     = '0;
    seed        = 49884;
    sample_idx  = 0;
    table_ready = 1'b0;
    build_table();
    total_samples = 0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      total_samples += count_samples(table_cmd[i]);
    end
    table_ready = 1'b1;

    // Both FIFOs empty, no sample held
    idle_status                  = '0;
    idle_status.cmd_almost_empty = 1'b1;
    idle_status.cmd_empty        = 1'b1;
    idle_status.smp_empty        = 1'b1;
    idle_status.smp_almost_empty = 1'b1;

    repeat (8) @(posedge clk);
    #5;
    check_value("data_out", data_out, 16'h0000);
    check_value("irq", {15'b0, irq}, 16'h0000);
    rst = 1'b0;

    // Status moved away from the cleared snapshot
    wait_for_irq();
    host_read(`EBI_ADDR_STATUS, word);
    check_value("status", word, idle_status);
    @(posedge clk);
    #5;
    check_value("irq", {15'b0, irq}, 16'h0000);

    for (int i = 0; i < NUM_SINGLE; i++) begin
      send_command(table_cmd[i]);
      add_expected(table_cmd[i]);
      if (i == 0) begin
        wait_for_irq();
      end
      drain_expected();
    end

    // Queue several commands before reading anything back
    for (int i = NUM_SINGLE; i < NUM_ENTRIES; i++) begin
      send_command(table_cmd[i]);
      add_expected(table_cmd[i]);
    end
    drain_expected();

    repeat (4) @(posedge clk);
    host_read(`EBI_ADDR_STATUS, word);
    check_value("status", word, idle_status);

    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    int limit;
    wait (table_ready);
    limit = (total_samples + NUM_ENTRIES) * 200;
    repeat (limit) @(posedge clk);
    abort_run("Watchdog expired before the test sequence completed");
  end

endmodule

/* hw/ebi_top.sv */
`include "ebi_defs.svh"

module ebi_top (
  input  logic            clk,
  input  logic            rst,
  input  logic            cs,
  input  logic            rd,
  input  logic            wr,
  input  ebi_pkg::addr_t  addr,
  input  ebi_pkg::data_t  data_in,
  output ebi_pkg::data_t  data_out,
  output logic            irq
);

  // Command path
  logic          cmd_push;
  logic          cmd_pop;
  logic          cmd_full;
  logic          cmd_almost_full;
  logic          cmd_empty;
  logic          cmd_almost_empty;
  ebi_pkg::cmd_t cmd_wdata;
  ebi_pkg::cmd_t cmd_rdata;

  // Sample path
  logic           smp_push;
  logic           smp_pop;
  logic           smp_full;
  logic           smp_almost_full;
  logic           smp_empty;
  logic           smp_almost_empty;
  ebi_pkg::data_t smp_wdata;
  ebi_pkg::data_t smp_rdata;

  ebi_bridge u_bridge (
    .clk              (clk),
    .rst              (rst),
    .cs               (cs),
    .rd               (rd),
    .wr               (wr),
    .addr             (addr),
    .data_in          (data_in),
    .data_out         (data_out),
    .irq              (irq),
    .cmd_push         (cmd_push),
    .cmd_data         (cmd_wdata),
    .cmd_full         (cmd_full),
    .cmd_almost_full  (cmd_almost_full),
    .cmd_empty        (cmd_empty),
    .cmd_almost_empty (cmd_almost_empty),
    .smp_pop          (smp_pop),
    .smp_data         (smp_rdata),
    .smp_full         (smp_full),
    .smp_almost_full  (smp_almost_full),
    .smp_empty        (smp_empty),
    .smp_almost_empty (smp_almost_empty)
  );

  sync_fifo #(
    .WIDTH ($bits(ebi_pkg::cmd_t)),
    .DEPTH (`EBI_CMD_DEPTH)
  ) u_cmd_fifo (
    .clk          (clk),
    .rst          (rst),
    .push         (cmd_push),
    .push_data    (cmd_wdata),
    .pop          (cmd_pop),
    .pop_data     (cmd_rdata),
    .full         (cmd_full),
    .almost_full  (cmd_almost_full),
    .empty        (cmd_empty),
    .almost_empty (cmd_almost_empty)
  );

  sync_fifo #(
    .WIDTH ($bits(ebi_pkg::data_t)),
    .DEPTH (`EBI_SAMPLE_DEPTH)
  ) u_smp_fifo (
    .clk          (clk),
    .rst          (rst),
    .push         (smp_push),
    .push_data    (smp_wdata),
    .pop          (smp_pop),
    .pop_data     (smp_rdata),
    .full         (smp_full),
    .almost_full  (smp_almost_full),
    .empty        (smp_empty),
    .almost_empty (smp_almost_empty)
  );

  acq_sequencer u_seq (
    .clk       (clk),
    .rst       (rst),
    .cmd_data  (cmd_rdata),
    .cmd_empty (cmd_empty),
    .cmd_pop   (cmd_pop),
    .smp_push  (smp_push),
    .smp_data  (smp_wdata),
    .smp_full  (smp_full)
  );

endmodule

/* hw/acq_sequencer.sv */
`include "ebi_defs.svh"

module acq_sequencer (
  input  logic            clk,
  input  logic            rst,
  // Command FIFO, pop side
  input  ebi_pkg::cmd_t   cmd_data,
  input  logic            cmd_empty,
  output logic            cmd_pop,
  // Sample FIFO, push side
  output logic            smp_push,
  output ebi_pkg::data_t  smp_data,
  input  logic            smp_full
);

  ebi_pkg::seq_state_t state_q;

  ebi_pkg::data_t remaining;
  ebi_pkg::data_t value_q;
  ebi_pkg::data_t step_q;
  ebi_pkg::data_t mask_q;
  logic           ramp_q;
  logic           known_op;

  assign known_op = (cmd_data.opcode == `EBI_OP_RAMP) ||
                    (cmd_data.opcode == `EBI_OP_CONST);

  // Take a new command only when idle
  assign cmd_pop = (state_q == ebi_pkg::SEQ_IDLE) && !cmd_empty;

  // One sample per cycle, stall on full
  assign smp_push = (state_q == ebi_pkg::SEQ_RUN) && (remaining != '0) && !smp_full;
  assign smp_data = value_q ^ mask_q;

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= ebi_pkg::SEQ_IDLE;
      remaining <= '0;
    end else begin
      case (state_q)
        ebi_pkg::SEQ_IDLE: begin
          if (cmd_pop) begin
            // Unknown opcodes are consumed as empty bursts
            remaining <= known_op ? cmd_data.count : '0;
            state_q   <= ebi_pkg::SEQ_RUN;
          end
        end
        ebi_pkg::SEQ_RUN: begin
          if (remaining == '0) begin
            state_q <= ebi_pkg::SEQ_IDLE;
          end else if (smp_push) begin
            remaining <= remaining - 16'd1;
            if (remaining == 16'd1) begin
              state_q <= ebi_pkg::SEQ_IDLE;
            end
          end
        end
        default: state_q <= ebi_pkg::SEQ_IDLE;
      endcase
    end
  end

  // --------------------
  // Sample generator
  // --------------------
  always_ff @(posedge clk) begin
    if (cmd_pop) begin
      value_q <= cmd_data.start;
      step_q  <= cmd_data.step;
      mask_q  <= cmd_data.mask;
      ramp_q  <= (cmd_data.opcode == `EBI_OP_RAMP);
    end else if (smp_push && ramp_q) begin
      // Wraps modulo 2^16
      value_q <= value_q + step_q;
    end
  end

  // Command FIFO head holds until it is taken
  a_cmd_head_stable: assert property (@(posedge clk) disable iff (rst)
    (!cmd_empty && !cmd_pop) |=> $stable(cmd_data))
    else $error("command FIFO head changed without a pop");

endmodule

/* hw/ebi_bridge.sv */
`include "ebi_defs.svh"

module ebi_bridge (
  input  logic            clk,
  input  logic            rst,
  // Host bus
  input  logic            cs,
  input  logic            rd,
  input  logic            wr,
  input  ebi_pkg::addr_t  addr,
  input  ebi_pkg::data_t  data_in,
  output ebi_pkg::data_t  data_out,
  output logic            irq,
  // Command FIFO, push side
  output logic            cmd_push,
  output ebi_pkg::cmd_t   cmd_data,
  input  logic            cmd_full,
  input  logic            cmd_almost_full,
  input  logic            cmd_empty,
  input  logic            cmd_almost_empty,
  // Sample FIFO, pop side
  output logic            smp_pop,
  input  ebi_pkg::data_t  smp_data,
  input  logic            smp_full,
  input  logic            smp_almost_full,
  input  logic            smp_empty,
  input  logic            smp_almost_empty
);

  ebi_pkg::bridge_state_t state_q;
  ebi_pkg::bridge_state_t state_d;

  // Command words as written by the host
  ebi_pkg::data_t cmd_w1;
  ebi_pkg::data_t cmd_w2;
  ebi_pkg::data_t cmd_w3;
  ebi_pkg::data_t cmd_w4;
  ebi_pkg::data_t cmd_w5;

  ebi_pkg::status_t status_next;
  ebi_pkg::status_t status_q;
  ebi_pkg::status_t status_last;

  ebi_pkg::data_t sample_q;
  logic           sample_valid;

  logic host_rd;
  logic host_wr;
  logic rd_d;
  logic rd_dd;
  logic rd_done;
  logic word_we;
  logic sample_done;

  assign host_rd = cs & rd;
  assign host_wr = cs & wr;

  // --------------------
  // Strobe edge detect
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_d  <= 1'b0;
      rd_dd <= 1'b0;
    end else begin
      rd_d  <= host_rd;
      rd_dd <= rd_d;
    end
  end

  // Read finished once the registered strobe drops
  assign rd_done = rd_dd & ~rd_d;

  // --------------------
  // Bus FSM
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ebi_pkg::BR_FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d     = state_q;
    word_we     = 1'b0;
    cmd_push    = 1'b0;
    smp_pop     = 1'b0;
    sample_done = 1'b0;
    case (state_q)
      ebi_pkg::BR_FETCH: begin
        if (host_wr) begin
          word_we = 1'b1;
          if (addr == `EBI_ADDR_CMD_W5) begin
            state_d = ebi_pkg::BR_CMD_LOAD;
          end
        end else if (host_rd && addr == `EBI_ADDR_SAMPLE) begin
          state_d = ebi_pkg::BR_SMP_READ;
        end else if (!sample_valid && !smp_empty) begin
          // Prefetch the next sample into the holding register
          smp_pop = 1'b1;
        end
      end
      ebi_pkg::BR_CMD_LOAD: begin
        // Hold here under back-pressure
        if (!cmd_full) begin
          cmd_push = 1'b1;
          state_d  = ebi_pkg::BR_TRANS_OVER;
        end
      end
      ebi_pkg::BR_TRANS_OVER: begin
        if (!rd && !wr) begin
          state_d = ebi_pkg::BR_FETCH;
        end
      end
      ebi_pkg::BR_SMP_READ: begin
        if (rd_done) begin
          sample_done = 1'b1;
          state_d     = ebi_pkg::BR_FETCH;
        end
      end
      default: state_d = ebi_pkg::BR_FETCH;
    endcase
  end

  // --------------------
  // Command assembly
  // --------------------
  always_ff @(posedge clk) begin
    if (word_we) begin
      case (addr)
        `EBI_ADDR_CMD_W1: cmd_w1 <= data_in;
        `EBI_ADDR_CMD_W2: cmd_w2 <= data_in;
        `EBI_ADDR_CMD_W3: cmd_w3 <= data_in;
        `EBI_ADDR_CMD_W4: cmd_w4 <= data_in;
        `EBI_ADDR_CMD_W5: cmd_w5 <= data_in;
        default: ;
      endcase
    end
  end

  always_comb begin
    cmd_data.opcode = cmd_w1;
    cmd_data.count  = cmd_w2;
    cmd_data.start  = cmd_w3;
    cmd_data.step   = cmd_w4;
    cmd_data.mask   = cmd_w5;
  end

  // --------------------
  // Sample holding register
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      sample_valid <= 1'b0;
    end else if (smp_pop) begin
      sample_valid <= 1'b1;
    end else if (sample_done) begin
      sample_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (smp_pop) begin
      sample_q <= smp_data;
    end
  end

  // --------------------
  // Status, irq, read data
  // --------------------
  always_comb begin
    status_next                  = '0;
    status_next.cmd_almost_full  = cmd_almost_full;
    status_next.cmd_full         = cmd_full;
    status_next.cmd_almost_empty = cmd_almost_empty;
    status_next.cmd_empty        = cmd_empty;
    status_next.smp_almost_full  = smp_almost_full;
    status_next.smp_full         = smp_full;
    status_next.smp_empty        = smp_empty;
    status_next.smp_almost_empty = smp_almost_empty;
    status_next.sample_valid     = sample_valid;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      status_q    <= '0;
      status_last <= '0;
      irq         <= 1'b0;
      data_out    <= '0;
    end else begin
      status_q <= status_next;
      irq      <= (status_q != status_last);
      if (host_rd) begin
        if (addr == `EBI_ADDR_STATUS) begin
          data_out    <= status_q;
          status_last <= status_q;
        end else if (addr == `EBI_ADDR_SAMPLE) begin
          data_out <= sample_q;
        end
      end
    end
  end

  // Host strobes last at least two clocks
  a_strobe_hold: assert property (@(posedge clk) disable iff (rst)
    ($rose(host_rd) || $rose(host_wr)) |=> (host_rd || host_wr))
    else $error("host strobe shorter than two clocks");

  // Sample FIFO head only moves on a pop
  a_smp_head_stable: assert property (@(posedge clk) disable iff (rst)
    (!smp_empty && !smp_pop) |=> $stable(smp_data))
    else $error("sample FIFO head changed without a pop");

endmodule

/* hw/sync_fifo.sv */
module sync_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             full,
  output logic             almost_full,
  output logic             empty,
  output logic             almost_empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);
  localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
  localparam logic [CW-1:0] FULL_CNT = CW'(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // --------------------
  // Flags
  // --------------------
  assign full         = (count == FULL_CNT);
  assign almost_full  = (count >= FULL_CNT - CW'(1));
  assign empty        = (count == '0);
  assign almost_empty = (count <= CW'(1));

  // Head is visible as soon as it is written
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + AW'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + AW'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + CW'(1);
        2'b01:   count <= count - CW'(1);
        default: ;
      endcase
    end
  end

  // Callers must respect the flags
  a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("push while FIFO full");
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
    else $error("pop while FIFO empty");

endmodule

/* hw/ebi_pkg.sv */
package ebi_pkg;

  // Bus word and sample word share one width
  typedef logic [15:0] data_t;

  // External bus address
  typedef logic [18:0] addr_t;

  // One command as written by the host
  // Word 1 lands in the top bits
  typedef struct packed {
    data_t opcode;
    data_t count;
    data_t start;
    data_t step;
    data_t mask;
  } cmd_t;

  // Status register as seen at address 0
  typedef struct packed {
    logic       cmd_almost_full;
    logic       cmd_full;
    logic       cmd_almost_empty;
    logic       cmd_empty;
    logic       smp_almost_full;
    logic       smp_full;
    logic       smp_empty;
    logic       smp_almost_empty;
    logic [6:0] reserved;
    logic       sample_valid;
  } status_t;

  typedef enum logic [1:0] {
    BR_FETCH,
    BR_CMD_LOAD,
    BR_TRANS_OVER,
    BR_SMP_READ
  } bridge_state_t;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_RUN
  } seq_state_t;

endpackage

/* include/ebi_defs.svh */
`ifndef EBI_DEFS_SVH
`define EBI_DEFS_SVH

// --------------------
// Host bus address map
// --------------------
`define EBI_ADDR_STATUS  19'd0
`define EBI_ADDR_CMD_W1  19'd1
`define EBI_ADDR_CMD_W2  19'd2
`define EBI_ADDR_CMD_W3  19'd3
`define EBI_ADDR_CMD_W4  19'd4
`define EBI_ADDR_CMD_W5  19'd5
`define EBI_ADDR_SAMPLE  19'd6

// --------------------
// FIFO depths
// --------------------
`define EBI_CMD_DEPTH     4
`define EBI_SAMPLE_DEPTH  16

// Sequencer opcodes, anything else runs silently
`define EBI_OP_RAMP   16'h0001
`define EBI_OP_CONST  16'h0002

`endif
